/* l2_bif_pkg.sv */
package l2_bif_pkg;

	// Line address splits into tag and set
	localparam int LINE_ADDR_W = 26;
	localparam int SET_W = 8;
	localparam int TAG_W = LINE_ADDR_W - SET_W;
	localparam int CORE_W = 2;

	// 32-bit words per line, also the burst length
	localparam int LINE_WORDS = 16;
	localparam int LINE_BITS = LINE_WORDS * 32;

	typedef enum logic [2:0]
	{
		L2REQ_LOAD = 3'd0,
		L2REQ_STORE = 3'd1,
		L2REQ_FLUSH = 3'd2,
		L2REQ_INVALIDATE = 3'd3,
		L2REQ_LOAD_SYNC = 3'd4,
		L2REQ_STORE_SYNC = 3'd5
	} l2req_op_e;

	// Request as it is reissued into the pipeline
	typedef struct packed
	{
		logic [CORE_W - 1:0] core;
		logic [1:0] unit;
		logic [1:0] strand;
		l2req_op_e op;
		logic [1:0] way;
		logic [LINE_ADDR_W - 1:0] address;
		logic [LINE_BITS - 1:0] data;
		logic [63:0] mask;
	} l2req_t;

	// Packet from the L2 read stage
	typedef struct packed
	{
		logic valid;
		l2req_t req;
		logic is_fill;
		logic cache_hit;
		logic [LINE_BITS - 1:0] mem_result;
		logic [TAG_W - 1:0] old_tag;
		logic line_dirty;
	} rd_stage_t;

	typedef struct packed
	{
		logic [LINE_ADDR_W - 1:0] address;
		logic [LINE_BITS - 1:0] data;
	} wb_entry_t;

	typedef struct packed
	{
		logic duplicate;
		l2req_t req;
	} load_entry_t;

	// Master side of the burst port
	typedef struct packed
	{
		logic [31:0] awaddr;
		logic [7:0] awlen;
		logic awvalid;
		logic [31:0] wdata;
		logic wlast;
		logic wvalid;
		logic bready;
		logic [31:0] araddr;
		logic [7:0] arlen;
		logic arvalid;
		logic rready;
	} axi_m_t;

	// Slave side of the burst port
	typedef struct packed
	{
		logic awready;
		logic wready;
		logic bvalid;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
	} axi_s_t;

endpackage

/* sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo
	#(parameter int DATA_WIDTH = 32,
	parameter int NUM_ENTRIES = 8,
	parameter int ALMOST_FULL_THRESHOLD = 4)
	(input logic clk,
	input logic reset,
	input logic enqueue_i,
	input logic [DATA_WIDTH - 1:0] value_i,
	input logic dequeue_i,
	output logic [DATA_WIDTH - 1:0] value_o,
	output logic empty_o,
	output logic full_o,
	output logic almost_full_o);

	localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
	localparam int CNT_W = $clog2(NUM_ENTRIES + 1);

	logic [DATA_WIDTH - 1:0] storage [NUM_ENTRIES];
	logic [PTR_W - 1:0] read_ptr;
	logic [PTR_W - 1:0] write_ptr;
	logic [CNT_W - 1:0] count;
	logic do_enqueue;
	logic do_dequeue;

	// Ignore pushes when full and pops when empty
	assign do_enqueue = enqueue_i && !full_o;
	assign do_dequeue = dequeue_i && !empty_o;

	assign empty_o = count == '0;
	assign full_o = count == CNT_W'(NUM_ENTRIES);
	assign almost_full_o = count >= CNT_W'(NUM_ENTRIES - ALMOST_FULL_THRESHOLD);

	// Head entry is visible without a pop
	assign value_o = storage[read_ptr];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_enqueue)
				write_ptr <= (write_ptr == PTR_W'(NUM_ENTRIES - 1)) ? '0 : write_ptr + 1'b1;

			if (do_dequeue)
				read_ptr <= (read_ptr == PTR_W'(NUM_ENTRIES - 1)) ? '0 : read_ptr + 1'b1;

			// Simultaneous push and pop leave the count unchanged
			if (do_enqueue && !do_dequeue)
				count <= count + 1'b1;
			else if (do_dequeue && !do_enqueue)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_enqueue)
			storage[write_ptr] <= value_i;
	end

endmodule

/* l2_pending_miss.sv */
`timescale 1ns/1ps

module l2_pending_miss import l2_bif_pkg::*;
	#(parameter int NUM_PENDING = 4)
	(input logic clk,
	input logic reset,
	input logic enqueue_load_i,
	input logic fill_i,
	input logic [LINE_ADDR_W - 1:0] address_i,
	output logic duplicate_o);

	localparam int IDX_W = (NUM_PENDING > 1) ? $clog2(NUM_PENDING) : 1;

	logic [NUM_PENDING - 1:0] entry_valid;
	logic [LINE_ADDR_W - 1:0] entry_address [NUM_PENDING];
	logic [NUM_PENDING - 1:0] entry_hit;
	logic free_found;
	logic [IDX_W - 1:0] free_idx;

	// Compare the incoming line against every outstanding fetch
	always_comb
	begin
		for (int i = 0; i < NUM_PENDING; i++)
			entry_hit[i] = entry_valid[i] && entry_address[i] == address_i;
	end

	// Lowest numbered free slot
	always_comb
	begin
		free_found = 1'b0;
		free_idx = '0;
		for (int i = 0; i < NUM_PENDING; i++)
		begin
			if (!entry_valid[i] && !free_found)
			begin
				free_found = 1'b1;
				free_idx = IDX_W'(i);
			end
		end
	end

	// Line already on its way, so the load only needs a reissue
	assign duplicate_o = enqueue_load_i && |entry_hit;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			entry_valid <= '0;
		else
		begin
			// Fill for this line retires the fetch
			if (fill_i)
				entry_valid <= entry_valid & ~entry_hit;

			// Table full means the load goes to the bus as a normal miss
			if (enqueue_load_i && !(|entry_hit) && free_found)
				entry_valid[free_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (enqueue_load_i && !(|entry_hit) && free_found)
			entry_address[free_idx] <= address_i;
	end

endmodule

/* l2_axi_master.sv */
`timescale 1ns/1ps

module l2_axi_master import l2_bif_pkg::*;
	(input logic clk,
	input logic reset,
	input logic wb_pending_i,
	input wb_entry_t wb_head_i,
	output logic wb_done_o,
	input logic load_pending_i,
	input load_entry_t load_head_i,
	output logic data_ready_o,
	output logic [LINE_BITS - 1:0] load_line_o,
	output axi_m_t axi_m_o,
	input axi_s_t axi_s_i);

	localparam int BEAT_W = $clog2(LINE_WORDS);

	typedef enum logic [2:0]
	{
		ST_IDLE,
		ST_WRITE_ADDR,
		ST_WRITE_XFER,
		ST_READ_ADDR,
		ST_READ_XFER,
		ST_READ_COMPLETE
	} bus_state_e;

	bus_state_e state;
	bus_state_e state_nxt;
	logic [BEAT_W - 1:0] beat;
	logic [BEAT_W - 1:0] beat_nxt;
	logic last_beat;
	logic wait_write_resp;
	logic [31:0] line_buf [LINE_WORDS];

	assign last_beat = beat == BEAT_W'(LINE_WORDS - 1);

	// Word 0 sits in the most significant slice
	always_comb
	begin
		for (int k = 0; k < LINE_WORDS; k++)
			load_line_o[(LINE_WORDS - 1 - k) * 32 +: 32] = line_buf[k];
	end

	always_comb
	begin
		state_nxt = state;
		beat_nxt = beat;
		wb_done_o = 1'b0;
		data_ready_o = 1'b0;

		axi_m_o.awaddr = {wb_head_i.address, 6'd0};
		axi_m_o.awlen = 8'(LINE_WORDS);
		axi_m_o.awvalid = 1'b0;
		// Beat k drives word k of the head line
		axi_m_o.wdata = wb_head_i.data[(LINE_WORDS - 1 - int'(beat)) * 32 +: 32];
		axi_m_o.wlast = 1'b0;
		axi_m_o.wvalid = 1'b0;
		axi_m_o.bready = 1'b1;
		axi_m_o.araddr = {load_head_i.req.address, 6'd0};
		axi_m_o.arlen = 8'(LINE_WORDS);
		axi_m_o.arvalid = 1'b0;
		axi_m_o.rready = 1'b0;

		case (state)
			ST_IDLE:
			begin
				// Writebacks first so a load never sees stale memory
				if (wb_pending_i)
				begin
					if (!wait_write_resp)
						state_nxt = ST_WRITE_ADDR;
				end
				else if (load_pending_i)
				begin
					// Duplicate only needs a reissue
					if (load_head_i.duplicate)
						state_nxt = ST_READ_COMPLETE;
					else
						state_nxt = ST_READ_ADDR;
				end
			end

			ST_WRITE_ADDR:
			begin
				axi_m_o.awvalid = 1'b1;
				beat_nxt = '0;
				if (axi_s_i.awready)
					state_nxt = ST_WRITE_XFER;
			end

			ST_WRITE_XFER:
			begin
				axi_m_o.wvalid = 1'b1;
				axi_m_o.wlast = last_beat;
				if (axi_s_i.wready)
				begin
					beat_nxt = beat + 1'b1;
					if (last_beat)
					begin
						// Whole line is on the bus so the queue entry is released
						wb_done_o = 1'b1;
						state_nxt = ST_IDLE;
					end
				end
			end

			ST_READ_ADDR:
			begin
				axi_m_o.arvalid = 1'b1;
				beat_nxt = '0;
				if (axi_s_i.arready)
					state_nxt = ST_READ_XFER;
			end

			ST_READ_XFER:
			begin
				axi_m_o.rready = 1'b1;
				if (axi_s_i.rvalid)
				begin
					beat_nxt = beat + 1'b1;
					if (last_beat)
						state_nxt = ST_READ_COMPLETE;
				end
			end

			ST_READ_COMPLETE:
			begin
				// Request goes back to the pipeline and pops the load queue
				data_ready_o = 1'b1;
				state_nxt = ST_IDLE;
			end

			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			beat <= '0;
			wait_write_resp <= 1'b0;
			for (int k = 0; k < LINE_WORDS; k++)
				line_buf[k] <= '0;
		end
		else
		begin
			state <= state_nxt;
			beat <= beat_nxt;

			if (state == ST_READ_XFER && axi_s_i.rvalid)
				line_buf[beat] <= axi_s_i.rdata;

			// One write response outstanding at most
			if (state == ST_WRITE_ADDR)
				wait_write_resp <= 1'b1;
			else if (axi_s_i.bvalid)
				wait_write_resp <= 1'b0;
		end
	end

endmodule

/* l2_bus_interface.sv */
`timescale 1ns/1ps

module l2_bus_interface import l2_bif_pkg::*;
	#(parameter int QUEUE_DEPTH = 8,
	parameter int L2REQ_LATENCY = 4,
	parameter int NUM_PENDING = 4)
	(input logic clk,
	input logic reset,
	input rd_stage_t rd_i,
	output logic bif_input_wait_o,
	output l2req_t bif_req_o,
	output logic bif_duplicate_o,
	output logic [LINE_BITS - 1:0] bif_load_buffer_o,
	output logic bif_data_ready_o,
	output axi_m_t axi_m_o,
	input axi_s_t axi_s_i,
	output logic pc_event_l2_writeback_o);

	logic enqueue_wb;
	logic enqueue_load;
	logic duplicate;
	wb_entry_t wb_in;
	wb_entry_t wb_head;
	load_entry_t load_in;
	load_entry_t load_head;
	logic wb_empty;
	logic wb_almost_full;
	logic wb_done;
	logic load_empty;
	logic load_almost_full;

	// Dirty victim of a fill, or a dirty line being flushed
	assign enqueue_wb = rd_i.valid && rd_i.line_dirty
		&& (rd_i.is_fill || rd_i.req.op == L2REQ_FLUSH);

	// Miss on any request that needs the line
	assign enqueue_load = rd_i.valid && !rd_i.cache_hit && !rd_i.is_fill
		&& rd_i.req.op inside {L2REQ_LOAD, L2REQ_STORE, L2REQ_LOAD_SYNC, L2REQ_STORE_SYNC};

	always_comb
	begin
		// Victim address is the old tag with the set of the request
		wb_in.address = {rd_i.old_tag, rd_i.req.address[SET_W - 1:0]};
		wb_in.data = rd_i.mem_result;
		load_in.duplicate = duplicate;
		load_in.req = rd_i.req;
	end

	l2_pending_miss #(.NUM_PENDING(NUM_PENDING)) pending_miss (
		.clk(clk),
		.reset(reset),
		.enqueue_load_i(enqueue_load),
		.fill_i(rd_i.valid && rd_i.is_fill),
		.address_i(rd_i.req.address),
		.duplicate_o(duplicate));

	sync_fifo #(
		.DATA_WIDTH($bits(wb_entry_t)),
		.NUM_ENTRIES(QUEUE_DEPTH),
		.ALMOST_FULL_THRESHOLD(L2REQ_LATENCY)) writeback_queue (
		.clk(clk),
		.reset(reset),
		.enqueue_i(enqueue_wb),
		.value_i(wb_in),
		.dequeue_i(wb_done),
		.value_o(wb_head),
		.empty_o(wb_empty),
		.full_o(),
		.almost_full_o(wb_almost_full));

	sync_fifo #(
		.DATA_WIDTH($bits(load_entry_t)),
		.NUM_ENTRIES(QUEUE_DEPTH),
		.ALMOST_FULL_THRESHOLD(L2REQ_LATENCY)) load_queue (
		.clk(clk),
		.reset(reset),
		.enqueue_i(enqueue_load),
		.value_i(load_in),
		.dequeue_i(bif_data_ready_o),
		.value_o(load_head),
		.empty_o(load_empty),
		.full_o(),
		.almost_full_o(load_almost_full));

	l2_axi_master axi_master (
		.clk(clk),
		.reset(reset),
		.wb_pending_i(!wb_empty),
		.wb_head_i(wb_head),
		.wb_done_o(wb_done),
		.load_pending_i(!load_empty),
		.load_head_i(load_head),
		.data_ready_o(bif_data_ready_o),
		.load_line_o(bif_load_buffer_o),
		.axi_m_o(axi_m_o),
		.axi_s_i(axi_s_i));

	// Stall early enough for packets already in the pipeline
	assign bif_input_wait_o = wb_almost_full || load_almost_full;

	// Head of the load queue goes back to the pipeline
	assign bif_req_o = load_head.req;
	assign bif_duplicate_o = load_head.duplicate;

	assign pc_event_l2_writeback_o = enqueue_wb && !wb_almost_full;

endmodule

/* l2_bus_interface_chk.sv */
`timescale 1ns/1ps

module l2_bus_interface_chk import l2_bif_pkg::*;
	(input logic clk,
	input logic reset,
	input axi_m_t axi_m_i,
	input axi_s_t axi_s_i,
	input logic data_ready_i);

	// Nothing on the bus or the pipeline side while in reset
	assert property (@(posedge clk) reset |-> !(axi_m_i.awvalid || axi_m_i.wvalid
		|| axi_m_i.arvalid || axi_m_i.rready || data_ready_i))
		else $error("bus or data_ready active during reset");

	// Valid is held until the slave takes it
	assert property (@(posedge clk) disable iff (reset)
		axi_m_i.awvalid && !axi_s_i.awready |=> axi_m_i.awvalid)
		else $error("awvalid dropped before awready");
	assert property (@(posedge clk) disable iff (reset)
		axi_m_i.wvalid && !axi_s_i.wready |=> axi_m_i.wvalid)
		else $error("wvalid dropped before wready");
	assert property (@(posedge clk) disable iff (reset)
		axi_m_i.arvalid && !axi_s_i.arready |=> axi_m_i.arvalid)
		else $error("arvalid dropped before arready");

	assert property (@(posedge clk) disable iff (reset) axi_m_i.wlast |-> axi_m_i.wvalid)
		else $error("wlast without wvalid");

	// One pulse per completed load
	assert property (@(posedge clk) disable iff (reset) data_ready_i |=> !data_ready_i)
		else $error("data_ready high for two cycles");

endmodule

bind l2_bus_interface l2_bus_interface_chk chk (
	.clk(clk),
	.reset(reset),
	.axi_m_i(axi_m_o),
	.axi_s_i(axi_s_i),
	.data_ready_i(bif_data_ready_o));

/* tb_l2_bus_interface.sv */
`timescale 1ns/1ps

module tb_l2_bus_interface import l2_bif_pkg::*;
	();

	localparam int NUM_ROWS = 17;
	localparam logic [2:0] K_MISS = 3'd0;
	localparam logic [2:0] K_HIT = 3'd1;
	localparam logic [2:0] K_DFILL = 3'd2;
	localparam logic [2:0] K_CFILL = 3'd3;
	localparam logic [2:0] K_FLUSH = 3'd4;
	localparam logic [2:0] K_DRAIN = 3'd5;

	// One table row holds stimulus and expected increments
	typedef struct packed
	{
		logic [2:0] kind;
		logic [LINE_ADDR_W - 1:0] addr;
		logic [TAG_W - 1:0] old_tag;
		logic stall;
		logic wait_done;
		logic [1:0] exp_bursts;
		logic [1:0] exp_ready;
		logic exp_dup;
		logic [1:0] exp_wait;
	} row_t;

	logic clk;
	logic reset;
	rd_stage_t rd;
	axi_m_t axi_m;
	axi_s_t axi_s;
	logic input_wait;
	l2req_t req;
	logic dup;
	logic [LINE_BITS - 1:0] load_buf;
	logic data_ready;
	logic pc_event;

	row_t rows[$];
	logic [31:0] lcg_state = 32'd76576;
	logic [31:0] mem [logic [31:0]];
	l2req_t exp_req_q[$];
	logic exp_dup_q[$];
	logic [LINE_BITS - 1:0] exp_wb_q[$];
	logic [7:0] exp_kind_q[$];
	logic [31:0] exp_baddr_q[$];
	int burst_cnt = 0;
	int ready_cnt = 0;
	int pc_cnt = 0;
	int errors = 0;
	int checks = 0;
	// Memory model state
	logic mem_stall = 1'b0;
	logic b_pending = 1'b0;
	logic rd_active = 1'b0;
	logic [31:0] wr_addr = '0;
	logic [31:0] rd_addr = '0;
	int wr_beat = 0;
	int rd_beat = 0;

	l2_bus_interface uut (
		.clk(clk),
		.reset(reset),
		.rd_i(rd),
		.bif_input_wait_o(input_wait),
		.bif_req_o(req),
		.bif_duplicate_o(dup),
		.bif_load_buffer_o(load_buf),
		.bif_data_ready_o(data_ready),
		.axi_m_o(axi_m),
		.axi_s_i(axi_s),
		.pc_event_l2_writeback_o(pc_event));

	always #2 clk = !clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Words appear on first touch, so reads and expectations agree
	function automatic logic [31:0] peek(logic [31:0] a);
		if (!mem.exists(a))
			mem[a] = lcg_next();
		return mem[a];
	endfunction

	task automatic check_hex(string name, logic [639:0] expv, logic [639:0] actv);
		checks++;
		if (expv !== actv)
		begin
			errors++;
			$display("ERR %s expected %0h got %0h", name, expv, actv);
		end
	endtask

	task automatic fail_note(string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic add_row(logic [2:0] kind, logic [LINE_ADDR_W - 1:0] addr,
		logic [TAG_W - 1:0] tag, logic stall, logic wait_done, logic [1:0] bursts,
		logic [1:0] ready, logic exp_dup, logic [1:0] exp_wait);
		rows.push_back({kind, addr, tag, stall, wait_done, bursts, ready, exp_dup, exp_wait});
	endtask

	// Burst seen on the bus, compared with the expected order
	task automatic log_burst(logic [7:0] kind, logic [31:0] addr, logic [7:0] len);
		burst_cnt++;
		check_hex("burst_len", 640'(LINE_WORDS), 640'(len));
		if (exp_kind_q.size() == 0)
			fail_note("unexpected burst on the bus");
		else
		begin
			check_hex("burst_kind", 640'(exp_kind_q.pop_front()), 640'(kind));
			check_hex("burst_addr", 640'(exp_baddr_q.pop_front()), 640'(addr));
		end
	endtask

	// Memory model samples handshakes at the rising edge
	always @(posedge clk)
	begin
		logic [LINE_BITS - 1:0] line;
		l2req_t want_req;
		if (!reset)
		begin
			if (axi_m.awvalid && axi_s.awready)
			begin
				log_burst("W", axi_m.awaddr, axi_m.awlen);
				wr_addr = axi_m.awaddr;
				wr_beat = 0;
			end
			if (axi_m.wvalid && axi_s.wready)
			begin
				if (exp_wb_q.size() == 0)
					fail_note("write beat with no writeback pending");
				else
					check_hex("wdata", 640'(exp_wb_q[0][(15 - wr_beat) * 32 +: 32]),
						640'(axi_m.wdata));
				check_hex("wlast", 640'(wr_beat == 15), 640'(axi_m.wlast));
				mem[wr_addr + 32'(4 * wr_beat)] = axi_m.wdata;
				wr_beat++;
				if (wr_beat == 16)
				begin
					if (exp_wb_q.size() != 0)
						void'(exp_wb_q.pop_front());
					b_pending = 1'b1;
				end
			end
			if (axi_s.bvalid)
			begin
				check_hex("bready", 640'(1), 640'(axi_m.bready));
				b_pending = 1'b0;
			end
			if (axi_m.arvalid && axi_s.arready)
			begin
				log_burst("R", axi_m.araddr, axi_m.arlen);
				rd_active = 1'b1;
				rd_addr = axi_m.araddr;
				rd_beat = 0;
			end
			if (axi_s.rvalid && axi_m.rready)
			begin
				rd_beat++;
				if (rd_beat == 16)
					rd_active = 1'b0;
			end
			if (pc_event)
				pc_cnt++;
			if (data_ready)
			begin
				ready_cnt++;
				if (exp_req_q.size() == 0)
					fail_note("data_ready with no load outstanding");
				else
				begin
					want_req = exp_req_q.pop_front();
					check_hex("bif_req_o", 640'(want_req), 640'(req));
					check_hex("bif_duplicate_o", 640'(exp_dup_q.pop_front()), 640'(dup));
					for (int k = 0; k < 16; k++)
						line[(15 - k) * 32 +: 32] = peek({want_req.address, 6'd0}
							+ 32'(4 * k));
					check_hex("bif_load_buffer_o", 640'(line), 640'(load_buf));
				end
			end
		end
	end

	// Slave side is driven on the falling edge with stalls picked by the LCG
	always @(negedge clk)
	begin
		logic [31:0] r;
		r = lcg_next();
		axi_s.awready = !reset && !mem_stall && r[16];
		axi_s.wready = !reset && !mem_stall && r[18];
		axi_s.arready = !reset && !mem_stall && r[20];
		axi_s.rvalid = !reset && rd_active && !mem_stall && r[22];
		axi_s.rdata = rd_active ? peek(rd_addr + 32'(4 * rd_beat)) : '0;
		axi_s.bvalid = !reset && b_pending;
	end

	// Read-stage driver sends one packet per row
	task automatic send_row(row_t row);
		logic is_dirty;
		is_dirty = row.kind == K_DFILL || row.kind == K_FLUSH;
		while (input_wait)
			@(negedge clk);
		rd = '0;
		rd.valid = 1'b1;
		rd.req.core = CORE_W'(lcg_next());
		rd.req.strand = 2'(lcg_next());
		rd.req.op = row.kind == K_FLUSH ? L2REQ_FLUSH : L2REQ_LOAD;
		rd.req.address = row.addr;
		rd.req.mask = {lcg_next(), lcg_next()};
		rd.cache_hit = row.kind == K_HIT || row.kind == K_FLUSH;
		rd.is_fill = row.kind == K_DFILL || row.kind == K_CFILL;
		rd.line_dirty = is_dirty;
		rd.old_tag = row.old_tag;
		for (int k = 0; k < 16; k++)
			rd.mem_result[k * 32 +: 32] = lcg_next();
		if (is_dirty)
		begin
			exp_wb_q.push_back(rd.mem_result);
			exp_kind_q.push_back("W");
			exp_baddr_q.push_back({row.old_tag, row.addr[SET_W - 1:0], 6'd0});
		end
		if (row.kind == K_MISS)
		begin
			exp_req_q.push_back(rd.req);
			exp_dup_q.push_back(row.exp_dup);
			if (!row.exp_dup)
			begin
				exp_kind_q.push_back("R");
				exp_baddr_q.push_back({row.addr, 6'd0});
			end
		end
		@(negedge clk);
		rd.valid = 1'b0;
		if (row.exp_wait != 2'd2)
			check_hex("bif_input_wait_o", 640'(row.exp_wait[0]), 640'(input_wait));
	endtask

	initial
	begin
		#(NUM_ROWS * 200 * 4);
		$display("watchdog expired before the table finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		int exp_b;
		int exp_r;
		int exp_pc;
		int n;
		int err_before;
		clk = 1'b0;
		reset = 1'b1;
		rd = '0;
		axi_s = '0;
		exp_b = 0;
		exp_r = 0;
		exp_pc = 0;
		// kind, address, old tag, stall, wait, bursts, ready, dup, input wait
		add_row(K_MISS, 26'h0012345, '0, 0, 1, 1, 1, 0, 2);
		add_row(K_HIT, 26'h0012345, '0, 0, 1, 0, 0, 0, 2);
		add_row(K_CFILL, 26'h0012345, 18'h00abc, 0, 1, 0, 0, 0, 2);
		add_row(K_DFILL, 26'h0200111, 18'h01234, 0, 1, 1, 0, 0, 2);
		add_row(K_FLUSH, 26'h0300222, 18'h03000, 0, 1, 1, 0, 0, 2);
		// Both writebacks queued ahead of the load
		add_row(K_DFILL, 26'h0400033, 18'h02f0f, 0, 0, 1, 0, 0, 2);
		add_row(K_FLUSH, 26'h0500044, 18'h00505, 0, 0, 1, 0, 0, 2);
		add_row(K_MISS, 26'h0600055, '0, 0, 1, 1, 1, 0, 2);
		// Second miss to a line in flight
		add_row(K_MISS, 26'h0700066, '0, 0, 0, 1, 1, 0, 2);
		add_row(K_MISS, 26'h0700066, '0, 0, 1, 0, 1, 1, 2);
		add_row(K_CFILL, 26'h0700066, 18'h01c00, 0, 1, 0, 0, 0, 2);
		add_row(K_MISS, 26'h0700066, '0, 0, 1, 1, 1, 0, 2);
		// Stalled memory lets the load queue fill to the wait level
		add_row(K_MISS, 26'h0800077, '0, 1, 0, 1, 1, 0, 0);
		add_row(K_MISS, 26'h0900088, '0, 1, 0, 1, 1, 0, 0);
		add_row(K_MISS, 26'h0a00099, '0, 1, 0, 1, 1, 0, 0);
		add_row(K_MISS, 26'h0b000aa, '0, 1, 0, 1, 1, 0, 1);
		add_row(K_DRAIN, '0, '0, 0, 1, 0, 0, 0, 2);
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++)
		begin
			err_before = errors;
			mem_stall = rows[i].stall;
			exp_b += rows[i].exp_bursts;
			exp_r += rows[i].exp_ready;
			if (rows[i].kind == K_DFILL || rows[i].kind == K_FLUSH)
				exp_pc++;
			if (rows[i].kind != K_DRAIN)
				send_row(rows[i]);
			if (rows[i].wait_done)
			begin
				n = 0;
				while ((burst_cnt < exp_b || ready_cnt < exp_r || exp_wb_q.size() != 0)
					&& n < 200)
				begin
					@(negedge clk);
					n++;
				end
				if (n == 200)
					fail_note($sformatf("row %0d timed out waiting for the bus", i));
				// Room for any stray extra event
				repeat (20) @(negedge clk);
				check_hex("burst count", 640'(exp_b), 640'(burst_cnt));
				check_hex("bif_data_ready_o count", 640'(exp_r), 640'(ready_cnt));
				check_hex("pc_event_l2_writeback_o count", 640'(exp_pc), 640'(pc_cnt));
			end
			$display("row %0d kind %0d done, %0d new errors", i, rows[i].kind,
				errors - err_before);
		end
		if (exp_kind_q.size() != 0 || exp_req_q.size() != 0)
			fail_note("expected bursts or loads never completed");
		check_hex("bif_input_wait_o", 640'(0), 640'(input_wait));
		$display("rows %0d checks %0d errors %0d", rows.size(), checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* build.f */
l2_bif_pkg.sv
sync_fifo.sv
l2_pending_miss.sv
l2_axi_master.sv
l2_bus_interface.sv
l2_bus_interface_chk.sv
tb_l2_bus_interface.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_l2_bus_interface -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED" ||
{ echo "simulation failed"; exit 1; }
